// ==== hw/replica_settings.svh ====
`ifndef REPLICA_SETTINGS_SVH
`define REPLICA_SETTINGS_SVH

// ##############################
// Chain geometry
// ##############################

`define REPLICA_NODE_NUM   8
`define REPLICA_IDX_W      3     // Node index width
`define REPLICA_DATA_W     24    // Signed energy word

// ##############################
// Boltzmann factor
// ##############################

`define REPLICA_EXP_STEPS  8     // Exponent argument bits, one run cycle each
`define REPLICA_FRAC_W     16    // Factor and threshold are FRAC_W+1 bits wide
`define REPLICA_X_SHIFT    4     // |delta| scaling before the exponent

// Operation word
`define REPLICA_OPT_W      48

`endif

// ==== hw/replica_pkg.sv ====
`default_nettype none
`include "replica_settings.svh"

package replica_pkg;

    // Command field, top two bits of every operation word
    localparam logic [1:0] COM_LOAD = 2'd0;
    localparam logic [1:0] COM_EXCH = 2'd1;
    localparam logic [1:0] COM_THR  = 2'd2; // Hold round, code 3 is reserved

    // Where a node's new energy came from
    localparam logic [1:0] XCH_NOP  = 2'd0;
    localparam logic [1:0] XCH_SELF = 2'd1;
    localparam logic [1:0] XCH_PREV = 2'd2;
    localparam logic [1:0] XCH_FOLW = 2'd3;

    // One word, two views selected by com
    typedef union packed {
        struct packed {
            logic [1:0]                          com;
            logic [`REPLICA_IDX_W-1:0]           idx;
            logic signed [`REPLICA_DATA_W-1:0]   value;
            logic [`REPLICA_OPT_W-2-`REPLICA_IDX_W-`REPLICA_DATA_W-1:0] pad;
        } load;
        struct packed {
            logic [1:0]                          com;
            logic                                parity;     // Pairing offset
            logic [`REPLICA_FRAC_W:0]            r_exchange; // Threshold, 1.0 = 2^16
            logic [`REPLICA_OPT_W-3-`REPLICA_FRAC_W-1-1:0] pad;
        } exch;
    } opt_word_u;

    // Entry k is round(2^16 * exp(-2^k / 16))
    localparam logic [`REPLICA_FRAC_W:0] EXP_RECIP [0:`REPLICA_EXP_STEPS-1] = '{
        17'd61565,
        17'd57835,
        17'd51039,
        17'd39750,
        17'd24109,
        17'd8869,
        17'd1200,
        17'd22
    };

endpackage

`default_nettype wire

// ==== hw/replica_seq.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "replica_settings.svh"

module replica_seq (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              opt_valid,
    input  replica_pkg::opt_word_u            opt_word,

    output logic                              load_en,
    output logic [`REPLICA_IDX_W-1:0]         load_idx,
    output logic signed [`REPLICA_DATA_W-1:0] load_value,

    output logic                              exp_init,
    output logic                              exp_run,
    output logic [`REPLICA_FRAC_W:0]          exp_recip,
    output logic                              exp_fin,

    output logic                              opt_run,
    output logic                              hold,
    output logic                              parity,
    output logic [`REPLICA_FRAC_W:0]          r_exchange,
    output logic                              busy,
    output logic                              round_done
);

    localparam int STEPS = `REPLICA_EXP_STEPS;
    localparam int CNT_W = $clog2(STEPS + 3);
    localparam int K_W   = $clog2(STEPS);

    logic [1:0]       com;
    logic             round_start;
    logic [CNT_W-1:0] step;       // 0 init, 1..STEPS run, then fin and commit
    logic [CNT_W-1:0] run_step;

    // ##############################
    // Command decode
    // ##############################

    assign com = opt_word.load.com; // Same bits in both views

    // Loads bypass the round machinery
    assign load_en    = opt_valid && !busy && (com == replica_pkg::COM_LOAD);
    assign load_idx   = opt_word.load.idx;
    assign load_value = opt_word.load.value;

    assign round_start = opt_valid && !busy &&
                         ((com == replica_pkg::COM_EXCH) || (com == replica_pkg::COM_THR));

    // ##############################
    // Round step counter
    // ##############################

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            round_done <= 1'b0;
            hold       <= 1'b0;
            step       <= '0;
        end else begin
            round_done <= 1'b0;
            if (round_start) begin
                busy <= 1'b1;
                step <= '0;
                hold <= (com == replica_pkg::COM_THR);
            end else if (busy) begin
                if (step == CNT_W'(STEPS + 2)) begin // Commit cycle ends the round
                    busy       <= 1'b0;
                    round_done <= 1'b1;
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    // Round arguments, held until the next accepted round
    always_ff @(posedge clk) begin
        if (round_start) begin
            parity     <= opt_word.exch.parity;
            r_exchange <= opt_word.exch.r_exchange;
        end
    end

    // Strobes to every node
    assign exp_init = busy && (step == '0);
    assign exp_run  = busy && (step >= CNT_W'(1)) && (step <= CNT_W'(STEPS));
    assign exp_fin  = busy && (step == CNT_W'(STEPS + 1));
    assign opt_run  = busy && (step == CNT_W'(STEPS + 2));

    assign run_step  = step - 1'b1;
    assign exp_recip = exp_run ? replica_pkg::EXP_RECIP[run_step[K_W-1:0]] : '0;

endmodule

`default_nettype wire

// ==== hw/boltz_exp.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "replica_settings.svh"

// Bitwise exponential: y = prod over set bits k of exp(-2^k / 16)
module boltz_exp #(
    parameter int STEPS = 8
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     init,
    input  logic                     run,
    input  logic [STEPS-1:0]         x,
    input  logic [`REPLICA_FRAC_W:0] recip,
    output logic [`REPLICA_FRAC_W:0] y
);

    localparam int FACT_W = `REPLICA_FRAC_W + 1;

    logic [STEPS-1:0]    x_q;  // Shifts down, bit 0 is the current step
    logic [2*FACT_W-1:0] prod;

    // Full width product, y never exceeds 1.0
    assign prod = y * recip;

    always_ff @(posedge clk) begin
        if (reset) begin
            y   <= '0;
            x_q <= '0;
        end else if (init) begin
            y   <= {1'b1, {`REPLICA_FRAC_W{1'b0}}}; // 1.0
            x_q <= x;
        end else if (run) begin
            if (x_q[0]) begin
                y <= prod[`REPLICA_FRAC_W +: FACT_W]; // Truncating rescale
            end
            x_q <= x_q >> 1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/replica.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "replica_settings.svh"

module replica #(
    parameter int id = 0
) (
    input  logic                              clk,
    input  logic                              reset,

    input  logic                              load_en,
    input  logic [`REPLICA_IDX_W-1:0]         load_idx,
    input  logic signed [`REPLICA_DATA_W-1:0] load_value,

    input  logic signed [`REPLICA_DATA_W-1:0] prev_data,
    input  logic signed [`REPLICA_DATA_W-1:0] folw_data,

    input  logic                              exp_init,
    input  logic                              exp_run,
    input  logic [`REPLICA_FRAC_W:0]          exp_recip,
    input  logic                              exp_fin,

    input  logic                              opt_run,
    input  logic                              hold,
    input  logic                              parity,
    input  logic [`REPLICA_FRAC_W:0]          r_exchange,

    output logic signed [`REPLICA_DATA_W-1:0] out_data,
    output logic [1:0]                        exch
);

    localparam int  DW       = `REPLICA_DATA_W;
    localparam int  STEPS    = `REPLICA_EXP_STEPS;
    localparam logic ID_ODD   = (id % 2) == 1;
    localparam logic HAS_PREV = id > 0;
    localparam logic HAS_FOLW = id < `REPLICA_NODE_NUM - 1;

    logic                 is_lower;
    logic                 is_upper;
    logic signed [DW:0]   delta;   // Upper minus lower, one guard bit
    logic [DW:0]          mag;
    logic [DW:0]          mag_sh;
    logic [STEPS-1:0]     x;
    logic [`REPLICA_FRAC_W:0] y;
    logic                 test;

    // Pair role from position and round parity
    assign is_lower = (ID_ODD == parity) && HAS_FOLW;
    assign is_upper = (ID_ODD != parity) && HAS_PREV;

    assign delta  = is_lower ? (folw_data - out_data) : (out_data - prev_data);
    assign mag    = delta[DW] ? -delta : delta;
    assign mag_sh = mag >> `REPLICA_X_SHIFT;
    assign x      = (|mag_sh[DW:STEPS]) ? '1 : mag_sh[STEPS-1:0]; // Saturate

    boltz_exp #(
        .STEPS (STEPS)
    ) u_exp (
        .clk   (clk),
        .reset (reset),
        .init  (exp_init),
        .run   (exp_run),
        .x     (x),
        .recip (exp_recip),
        .y     (y)
    );

    // ##############################
    // Decision and commit
    // ##############################

    always_ff @(posedge clk) begin
        if (reset) begin
            out_data <= '0;
            exch     <= replica_pkg::XCH_NOP;
            test     <= 1'b0;
        end else begin
            if (exp_fin) begin
                test <= !delta[DW] || (y > r_exchange); // Downhill or accepted uphill
            end
            if (opt_run) begin
                if (hold) begin
                    exch <= replica_pkg::XCH_NOP;
                end else if (test && is_lower) begin
                    out_data <= folw_data;
                    exch     <= replica_pkg::XCH_FOLW;
                end else if (test && is_upper) begin
                    out_data <= prev_data;
                    exch     <= replica_pkg::XCH_PREV;
                end else begin
                    exch <= replica_pkg::XCH_SELF; // Idle end node or rejected
                end
            end else begin
                exch <= replica_pkg::XCH_NOP;
                if (load_en && (load_idx == `REPLICA_IDX_W'(id))) begin
                    out_data <= load_value;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/replica_chain.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "replica_settings.svh"

module replica_chain (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          opt_valid,
    input  replica_pkg::opt_word_u                        opt_word,
    output logic [`REPLICA_NODE_NUM*`REPLICA_DATA_W-1:0]  energy_flat,
    output logic [2*`REPLICA_NODE_NUM-1:0]                exch_flat,
    output logic                                          busy,
    output logic                                          round_done
);

    localparam int N  = `REPLICA_NODE_NUM;
    localparam int DW = `REPLICA_DATA_W;

    // Broadcast from the sequencer
    logic                         load_en;
    logic [`REPLICA_IDX_W-1:0]    load_idx;
    logic signed [DW-1:0]         load_value;
    logic                         exp_init;
    logic                         exp_run;
    logic [`REPLICA_FRAC_W:0]     exp_recip;
    logic                         exp_fin;
    logic                         opt_run;
    logic                         hold;
    logic                         parity;
    logic [`REPLICA_FRAC_W:0]     r_exchange;

    replica_seq u_seq (
        .clk        (clk),
        .reset      (reset),
        .opt_valid  (opt_valid),
        .opt_word   (opt_word),
        .load_en    (load_en),
        .load_idx   (load_idx),
        .load_value (load_value),
        .exp_init   (exp_init),
        .exp_run    (exp_run),
        .exp_recip  (exp_recip),
        .exp_fin    (exp_fin),
        .opt_run    (opt_run),
        .hold       (hold),
        .parity     (parity),
        .r_exchange (r_exchange),
        .busy       (busy),
        .round_done (round_done)
    );

    // ##############################
    // Node line
    // ##############################

    for (genvar i = 0; i < N; i++) begin : g_node
        logic signed [DW-1:0] prev_data;
        logic signed [DW-1:0] folw_data;

        // End nodes see themselves as the missing neighbour
        if (i == 0) begin : g_first
            assign prev_data = energy_flat[0 +: DW];
        end else begin : g_prev
            assign prev_data = energy_flat[(i-1)*DW +: DW];
        end
        if (i == N - 1) begin : g_last
            assign folw_data = energy_flat[i*DW +: DW];
        end else begin : g_folw
            assign folw_data = energy_flat[(i+1)*DW +: DW];
        end

        replica #(
            .id (i)
        ) u_node (
            .clk        (clk),
            .reset      (reset),
            .load_en    (load_en),
            .load_idx   (load_idx),
            .load_value (load_value),
            .prev_data  (prev_data),
            .folw_data  (folw_data),
            .exp_init   (exp_init),
            .exp_run    (exp_run),
            .exp_recip  (exp_recip),
            .exp_fin    (exp_fin),
            .opt_run    (opt_run),
            .hold       (hold),
            .parity     (parity),
            .r_exchange (r_exchange),
            .out_data   (energy_flat[i*DW +: DW]),
            .exch       (exch_flat[2*i +: 2])
        );
    end

endmodule

`default_nettype wire

// ==== test/replica_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "replica_settings.svh"

module replica_tb;

    localparam int N         = `REPLICA_NODE_NUM;
    localparam int DW        = `REPLICA_DATA_W;
    localparam int STEPS     = `REPLICA_EXP_STEPS;
    localparam int ROUNDS    = 200;
    localparam int TIMEOUT   = 40;
    localparam int ROUND_LEN = `REPLICA_EXP_STEPS + 4; // Strobe to round_done
    localparam int ONE       = 1 << `REPLICA_FRAC_W;

    logic                   clk;
    logic                   reset;
    logic                   opt_valid;
    replica_pkg::opt_word_u opt_word;
    logic [N*DW-1:0]        energy_flat;
    logic [2*N-1:0]         exch_flat;
    logic                   busy;
    logic                   round_done;

    // Reference model state
    logic signed [DW-1:0] model_e [0:N-1];
    logic [1:0]           model_x [0:N-1];

    logic [31:0] rng;
    int          energy_errors;
    int          exch_errors;
    int          other_errors;
    bit          timed_out;

    replica_chain UUT (
        .clk         (clk),
        .reset       (reset),
        .opt_valid   (opt_valid),
        .opt_word    (opt_word),
        .energy_flat (energy_flat),
        .exch_flat   (exch_flat),
        .busy        (busy),
        .round_done  (round_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ##############################
    // Stimulus helpers
    // ##############################

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] t;
        t = s;
        t = t ^ (t << 13);
        t = t ^ (t >> 17);
        t = t ^ (t << 5);
        return t;
    endfunction

    // Mostly small energies so the factor lands inside its useful range
    function automatic logic signed [DW-1:0] pick_energy(input logic [31:0] r);
        if (r[31:29] == 3'd0) begin
            return r[DW-1:0];
        end
        return {{(DW-12){r[11]}}, r[11:0]};
    endfunction

    function automatic replica_pkg::opt_word_u load_word(
        input logic [`REPLICA_IDX_W-1:0] idx,
        input logic signed [DW-1:0]      value
    );
        replica_pkg::opt_word_u w;
        w            = '0;
        w.load.com   = replica_pkg::COM_LOAD;
        w.load.idx   = idx;
        w.load.value = value;
        return w;
    endfunction

    function automatic replica_pkg::opt_word_u round_word(
        input logic [1:0]                com,
        input logic                      par,
        input logic [`REPLICA_FRAC_W:0]  thr
    );
        replica_pkg::opt_word_u w;
        w                 = '0;
        w.exch.com        = com;
        w.exch.parity     = par;
        w.exch.r_exchange = thr;
        return w;
    endfunction

    // ##############################
    // Reference model
    // ##############################

    // Product of e^(-2^k/16) over the set bits of x with truncation at each step
    function automatic int boltz_factor(input int x);
        longint y;
        y = ONE;
        for (int k = 0; k < STEPS; k++) begin
            if (x[k]) begin
                y = (y * longint'(replica_pkg::EXP_RECIP[k])) >> `REPLICA_FRAC_W;
            end
        end
        return int'(y);
    endfunction

    task automatic model_round(input logic par, input logic is_hold, input int thr);
        logic signed [DW-1:0] next_e [0:N-1];
        int                   delta;
        int                   mag;
        int                   x;
        bit                   test;
        for (int i = 0; i < N; i++) begin
            next_e[i]  = model_e[i];
            model_x[i] = is_hold ? replica_pkg::XCH_NOP : replica_pkg::XCH_SELF;
        end
        if (!is_hold) begin
            for (int i = 0; i < N - 1; i++) begin
                if (((i + par) % 2) == 0) begin // Pair (i, i+1)
                    delta = int'(model_e[i+1]) - int'(model_e[i]);
                    mag   = (delta < 0) ? -delta : delta;
                    x     = mag >> `REPLICA_X_SHIFT;
                    if (x > (1 << STEPS) - 1) begin
                        x = (1 << STEPS) - 1;
                    end
                    test = (delta >= 0) || (boltz_factor(x) > thr);
                    if (test) begin
                        next_e[i]    = model_e[i+1];
                        next_e[i+1]  = model_e[i];
                        model_x[i]   = replica_pkg::XCH_FOLW;
                        model_x[i+1] = replica_pkg::XCH_PREV;
                    end
                end
            end
        end
        for (int i = 0; i < N; i++) begin
            model_e[i] = next_e[i];
        end
    endtask

    // ##############################
    // Compare tasks
    // ##############################

    task automatic check_energy(
        input string                name,
        input logic signed [DW-1:0] got,
        input logic signed [DW-1:0] expected
    );
        if (got !== expected) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, expected);
            energy_errors++;
        end
    endtask

    task automatic check_exch(input string name, input logic [1:0] got, input logic [1:0] expected);
        if (got !== expected) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, expected);
            exch_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("** Error at %0t: %s is %b, expected %b", $time, name, got, expected);
            other_errors++;
        end
    endtask

    task automatic check_state;
        for (int i = 0; i < N; i++) begin
            check_energy($sformatf("energy_flat[node %0d]", i), energy_flat[i*DW +: DW],
                         model_e[i]);
            check_exch($sformatf("exch_flat[node %0d]", i), exch_flat[2*i +: 2], model_x[i]);
        end
    endtask

    // ##############################
    // Bus actions
    // ##############################

    // Entered 1 ns after a rising edge and left one cycle later
    task automatic send_word(input replica_pkg::opt_word_u w);
        opt_word  = w;
        opt_valid = 1'b1;
        @(posedge clk);
        #1;
        opt_valid = 1'b0;
    endtask

    task automatic do_load(input logic [`REPLICA_IDX_W-1:0] idx, input logic signed [DW-1:0] v);
        send_word(load_word(idx, v));
        model_e[idx] = v;
        for (int i = 0; i < N; i++) begin
            model_x[i] = replica_pkg::XCH_NOP;
        end
        check_flag("busy", busy, 1'b0);
        check_flag("round_done", round_done, 1'b0);
        check_state();
    endtask

    // Optionally sends a stray word in cycle 4 while busy is high
    task automatic wait_round(input bit inject, input replica_pkg::opt_word_u junk);
        int cnt;
        cnt = 1;
        check_flag("busy", busy, 1'b1);
        while ((round_done !== 1'b1) && (cnt < TIMEOUT)) begin
            if (inject && (cnt == 4)) begin
                opt_word  = junk;
                opt_valid = 1'b1;
            end
            @(posedge clk);
            #1;
            opt_valid = 1'b0;
            cnt++;
        end
        if (round_done !== 1'b1) begin
            $display("Timed out after %0d cycles waiting for round_done at %0t", cnt, $time);
            other_errors++;
            timed_out = 1'b1;
        end else begin
            if (cnt != ROUND_LEN) begin
                $display("round_done came %0d cycles after the strobe instead of %0d",
                         cnt, ROUND_LEN);
                other_errors++;
            end
            check_flag("busy", busy, 1'b0);
        end
    endtask

    task automatic finish_run;
        $display("Errors: energy %0d, exch %0d, other %0d",
                 energy_errors, exch_errors, other_errors);
        if ((energy_errors + exch_errors + other_errors) == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    // ##############################
    // Main sequence
    // ##############################

    initial begin
        logic                          par;
        logic                          is_hold;
        int                            thr;
        bit                            inject;
        logic [`REPLICA_IDX_W-1:0]     idx;
        replica_pkg::opt_word_u        junk;

        reset         = 1'b1;
        opt_valid     = 1'b0;
        opt_word      = '0;
        rng           = 32'h0249_cf92;
        energy_errors = 0;
        exch_errors   = 0;
        other_errors  = 0;
        timed_out     = 1'b0;
        for (int i = 0; i < N; i++) begin
            model_e[i] = '0;
            model_x[i] = replica_pkg::XCH_NOP;
        end

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        check_flag("busy", busy, 1'b0);
        check_flag("round_done", round_done, 1'b0);
        check_state();

        for (int i = 0; i < N; i++) begin // Fill every node
            rng = xorshift(rng);
            do_load(i[`REPLICA_IDX_W-1:0], pick_energy(rng));
        end

        for (int n = 0; (n < ROUNDS) && !timed_out; n++) begin
            rng = xorshift(rng);
            if (rng[2:0] == 3'd0) begin // Occasional fresh energy
                idx = rng[12:10];
                rng = xorshift(rng);
                do_load(idx, pick_energy(rng));
            end

            rng     = xorshift(rng);
            par     = rng[0];
            is_hold = (rng[3:1] == 3'd0);
            inject  = (rng[9:7] == 3'd0);
            if (rng[6:4] == 3'd0) begin
                thr = 0;                    // Accepts any nonzero factor
            end else if (rng[6:4] == 3'd1) begin
                thr = ONE;                  // Rejects every uphill move
            end else begin
                thr = (rng >> 15) % (ONE + 1);
            end

            rng = xorshift(rng);
            if (rng[31]) begin
                junk = load_word(rng[2:0], pick_energy(xorshift(rng)));
            end else begin
                junk = round_word(replica_pkg::COM_EXCH, ~par, rng[16:0]);
            end

            send_word(round_word(is_hold ? replica_pkg::COM_THR : replica_pkg::COM_EXCH,
                                 par, thr[`REPLICA_FRAC_W:0]));
            wait_round(inject, junk);
            if (!timed_out) begin
                model_round(par, is_hold, thr);
                check_state();
            end
        end

        finish_run();
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hw
hw/replica_pkg.sv
hw/replica_seq.sv
hw/boltz_exp.sv
hw/replica.sv
hw/replica_chain.sv
test/replica_tb.sv
